/* common/mem_pkg.sv */
package mem_pkg;

	// ----------------------------------------
	// instruction fields
	// ----------------------------------------

	// load width codes in inst[9:7].
	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;

	// store widths share the low codes.
	localparam logic [2:0] F3_SB  = 3'b000;
	localparam logic [2:0] F3_SH  = 3'b001;
	localparam logic [2:0] F3_SW  = 3'b010;

	// opcode in inst[6:0].
	localparam logic [6:0] OP_LOAD  = 7'b0000011;
	localparam logic [6:0] OP_STORE = 7'b0100011;

	// ----------------------------------------
	// memory geometry and timing
	// ----------------------------------------

	localparam int RAM_WORDS  = 256;               // 32-bit words.
	localparam int RAM_ADDR_W = $clog2(RAM_WORDS); // word index width.

	// Wait states model a slow memory before the access cycle.
	localparam int RAM_WAIT = 3;
	localparam int WAIT_W   = 2;                   // holds RAM_WAIT - 1.

	// ----------------------------------------
	// bundled signals
	// ----------------------------------------

	// one request as presented at the stage input.
	typedef struct packed {
		logic [31:0] inst;  // opcode and funct3.
		logic [31:0] data;  // store value.
		logic [31:0] addr;  // byte address.
	} mem_req_t;

	// one RAM access, built by the aligner.
	typedef struct packed {
		logic [RAM_ADDR_W-1:0] index; // word index.
		logic [31:0]           wdata; // lane-aligned store data.
		logic [3:0]            wmask; // byte enables.
		logic                  we;
		logic                  re;
	} ram_port_t;

endpackage

/* src/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
	input  logic               clk,
	input  mem_pkg::ram_port_t ram,
	output logic [31:0]        rdata
);
	import mem_pkg::*;

	logic [31:0] mem [RAM_WORDS];

	// memory starts cleared.
	initial begin
		for (int i = 0; i < RAM_WORDS; i++)
			mem[i] = 32'h0;
	end

	// ----------------------------------------
	// write port with one enable per byte lane
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (ram.we) begin
			for (int b = 0; b < 4; b++) begin
				if (ram.wmask[b])
					mem[ram.index][b*8 +: 8] <= ram.wdata[b*8 +: 8];
			end
		end
	end

	// read port with one cycle latency.
	always_ff @(posedge clk) begin
		if (ram.re)
			rdata <= mem[ram.index];
	end

	// the aligner issues either a read or a write per request.
	a_we_re_exclusive: assert property (
		@(posedge clk) !(ram.we && ram.re)
	) else $error("data_ram: read and write in the same cycle");

endmodule

/* src/load_store_align.sv */
`timescale 1ns/1ps

module load_store_align (
	input  logic                clk,
	input  logic                reset,
	input  logic                capture,
	input  mem_pkg::mem_req_t   req,
	input  logic                access,
	input  logic                finish,
	input  logic [31:0]         rdata,
	output mem_pkg::ram_port_t  ram,
	output logic [31:0]         result
);
	import mem_pkg::*;

	mem_req_t    req_q;
	logic [2:0]  funct3;
	logic [6:0]  opcode;
	logic [1:0]  offset;
	logic [4:0]  lane_shift;
	logic [31:0] store_masked;
	logic [31:0] store_data;
	logic [3:0]  store_mask;
	logic [31:0] load_lane;
	logic [31:0] load_value;

	// held for the whole request.
	always_ff @(posedge clk) begin
		if (capture)
			req_q <= req;
	end

	assign funct3     = req_q.inst[9:7];
	assign opcode     = req_q.inst[6:0];
	assign offset     = req_q.addr[1:0];
	assign lane_shift = {offset, 3'b000}; // byte offset in bits.

	// ----------------------------------------
	// store path
	// ----------------------------------------

	always_comb begin
		case (funct3)
			F3_SB:   store_masked = {24'h0, req_q.data[7:0]};
			F3_SH:   store_masked = {16'h0, req_q.data[15:0]};
			F3_SW:   store_masked = req_q.data;
			default: store_masked = 32'h0;
		endcase
	end

	assign store_data = store_masked << lane_shift;

	always_comb begin
		case (funct3)
			F3_SB:   store_mask = 4'b0001 << offset;
			F3_SH:   store_mask = 4'b0011 << offset; // upper lane drops off at offset 3.
			F3_SW:   store_mask = 4'b1111;
			default: store_mask = 4'b0000;           // unknown width writes nothing.
		endcase
	end

	// strobes only in the access cycle.
	always_comb begin
		ram.index = req_q.addr[RAM_ADDR_W+1:2];
		ram.wdata = store_data;
		ram.wmask = store_mask;
		ram.we    = access && (opcode == OP_STORE);
		ram.re    = access && (opcode == OP_LOAD);
	end

	// ----------------------------------------
	// load path
	// ----------------------------------------

	// move the addressed lane down to bit 0.
	always_comb begin
		case (funct3)
			F3_LB, F3_LBU: load_lane = {24'h0, rdata[lane_shift +: 8]};
			F3_LH, F3_LHU: begin
				case (offset)
					2'b00:   load_lane = {16'h0, rdata[15:0]};
					2'b10:   load_lane = {16'h0, rdata[31:16]};
					default: load_lane = 32'h0; // odd halfword.
				endcase
			end
			F3_LW:   load_lane = rdata;
			default: load_lane = 32'h0;
		endcase
	end

	always_comb begin
		case (funct3)
			F3_LB:   load_value = {{24{load_lane[7]}}, load_lane[7:0]};
			F3_LH:   load_value = {{16{load_lane[15]}}, load_lane[15:0]};
			F3_LW, F3_LBU, F3_LHU: load_value = load_lane;
			default: load_value = 32'h0;
		endcase
	end

	// Stores and other opcodes complete with zero.
	always_ff @(posedge clk) begin
		if (reset)
			result <= 32'h0;
		else if (finish)
			result <= (opcode == OP_LOAD) ? load_value : 32'h0;
	end

endmodule

/* mem_ctrl/wait_counter.sv */
`timescale 1ns/1ps

module wait_counter (
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  logic en,
	output logic expired
);
	import mem_pkg::*;

	logic [WAIT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (reset)
			count <= '0;
		else if (load)
			count <= WAIT_W'(RAM_WAIT - 1);
		else if (en && (count != '0))
			count <= count - 1'b1; // stops at zero.
	end

	assign expired = en && (count == '0);

	// the controller leaves the wait state as soon as the count runs out.
	a_expire_once: assert property (
		@(posedge clk) disable iff (reset)
		(en && (count == '0)) |=> !(en && (count == '0))
	) else $error("wait_counter: enable held at zero");

endmodule

/* mem_ctrl/mem_ctrl_fsm.sv */
`timescale 1ns/1ps

module mem_ctrl_fsm (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic expired,
	output logic busy,
	output logic cnt_load,
	output logic cnt_en,
	output logic capture,
	output logic access,
	output logic finish,
	output logic done
);
	typedef enum logic [2:0] {
		st_idle,
		st_wait,
		st_access,
		st_result,
		st_done
	} state_t;

	state_t state;
	state_t state_next;

	always_ff @(posedge clk) begin
		if (reset)
			state <= st_idle;
		else
			state <= state_next;
	end

	// ----------------------------------------
	// next state
	// ----------------------------------------

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (start)
					state_next = st_wait;
			end
			st_wait: begin
				if (expired)
					state_next = st_access; // last wait state.
			end
			st_access: state_next = st_result;
			st_result: state_next = st_done;
			st_done:   state_next = st_idle;
			default:   state_next = st_idle;
		endcase
	end

	// ----------------------------------------
	// strobes decoded from state
	// ----------------------------------------

	assign busy     = (state != st_idle);
	assign capture  = (state == st_idle) && start;
	assign cnt_load = (state == st_idle) && start;
	assign cnt_en   = (state == st_wait);
	assign access   = (state == st_access);
	assign finish   = (state == st_result); // read data valid here.
	assign done     = (state == st_done);

	// one request in flight at a time.
	a_no_start_busy: assert property (
		@(posedge clk) disable iff (reset) busy |-> !start
	) else $error("mem_ctrl_fsm: start while busy");

	a_done_pulse: assert property (
		@(posedge clk) disable iff (reset) done |=> !done
	) else $error("mem_ctrl_fsm: done wider than one cycle");

endmodule

/* src/mem_stage_top.sv */
`timescale 1ns/1ps

module mem_stage_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  mem_pkg::mem_req_t req,
	output logic              busy,
	output logic              done,
	output logic [31:0]       result
);
	import mem_pkg::*;

	logic        cnt_load;
	logic        cnt_en;
	logic        expired;
	logic        capture;
	logic        access;
	logic        finish;
	ram_port_t   ram;
	logic [31:0] rdata;

	// ----------------------------------------
	// control
	// ----------------------------------------

	mem_ctrl_fsm mem_ctrl_fsm_i (
		.clk      (clk),
		.reset    (reset),
		.start    (start),
		.expired  (expired),
		.busy     (busy),
		.cnt_load (cnt_load),
		.cnt_en   (cnt_en),
		.capture  (capture),
		.access   (access),
		.finish   (finish),
		.done     (done)
	);

	wait_counter wait_counter_i (
		.clk     (clk),
		.reset   (reset),
		.load    (cnt_load),
		.en      (cnt_en),
		.expired (expired)
	);

	// ----------------------------------------
	// datapath
	// ----------------------------------------

	load_store_align load_store_align_i (
		.clk     (clk),
		.reset   (reset),
		.capture (capture),
		.req     (req),
		.access  (access),
		.finish  (finish),
		.rdata   (rdata),
		.ram     (ram),
		.result  (result)
	);

	data_ram data_ram_i (
		.clk   (clk),
		.ram   (ram),
		.rdata (rdata)
	);

endmodule

/* bench/mem_stage_tb.sv */
`timescale 1ns/1ps

module mem_stage_tb;
	import mem_pkg::*;

	localparam int NUM_REQ        = 400;
	localparam int RESET_REQ      = 8;                 // loads right after reset.
	localparam int DONE_CYCLE     = RAM_WAIT + 3;
	localparam int TIMEOUT_CYCLES = NUM_REQ * 8 + 20;

	logic        clk;
	logic        reset;
	logic        start;
	mem_req_t    req;
	logic        busy;
	logic        done;
	logic [31:0] result;

	logic [31:0] lfsr;
	int          cycle_count;
	logic [7:0]  model_mem [RAM_WORDS*4];             // byte image of the RAM.

	mem_stage_top mem_stage_top_i (
		.clk    (clk),
		.reset  (reset),
		.start  (start),
		.req    (req),
		.busy   (busy),
		.done   (done),
		.result (result)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ----------------------------------------
	// random bits and checks
	// ----------------------------------------

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr  = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, expected);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// ----------------------------------------
	// reference memory model
	// ----------------------------------------

	task automatic apply_store(input logic [31:0] addr, input logic [2:0] f3,
			input logic [31:0] data);
		logic [9:0]  base;
		logic [1:0]  off;
		logic [31:0] masked;
		logic [31:0] shifted;
		logic [3:0]  lanes;
		base = {addr[9:2], 2'b00};
		off  = addr[1:0];
		case (f3)
			F3_SB: begin
				masked = {24'h0, data[7:0]};
				lanes  = 4'b0001 << off;
			end
			F3_SH: begin
				masked = {16'h0, data[15:0]};
				lanes  = 4'b0011 << off;            // top byte lost at offset 3.
			end
			F3_SW: begin
				masked = data;
				lanes  = 4'b1111;
			end
			default: begin
				masked = 32'h0;
				lanes  = 4'b0000;
			end
		endcase
		shifted = masked << {off, 3'b000};
		for (int b = 0; b < 4; b++) begin
			if (lanes[b])
				model_mem[base + 10'(b)] = shifted[b*8 +: 8];
		end
	endtask

	function automatic logic [31:0] predict_load(input logic [31:0] addr,
			input logic [2:0] f3);
		logic [9:0]  base;
		logic [1:0]  off;
		logic [31:0] word;
		logic [7:0]  byte_val;
		logic [15:0] half_val;
		base     = {addr[9:2], 2'b00};
		off      = addr[1:0];
		word     = {model_mem[base + 10'd3], model_mem[base + 10'd2],
			model_mem[base + 10'd1], model_mem[base]};
		byte_val = word[{off, 3'b000} +: 8];
		half_val = word[{off[1], 4'b0000} +: 16];
		case (f3)
			F3_LB:  return {{24{byte_val[7]}}, byte_val};
			F3_LBU: return {24'h0, byte_val};
			F3_LH:  return off[0] ? 32'h0 : {{16{half_val[15]}}, half_val};
			F3_LHU: return off[0] ? 32'h0 : {16'h0, half_val};
			F3_LW:  return word;
			default: return 32'h0;
		endcase
	endfunction

	// ----------------------------------------
	// one request from start to done
	// ----------------------------------------

	task automatic run_request(input int num, input mem_req_t r, input logic [31:0] expected);
		logic [31:0] held;
		int          cycles;
		held  = result;
		req   = r;
		start = 1'b1;
		@(negedge clk);
		start  = 1'b0;
		cycles = 1;
		while (done !== 1'b1) begin
			if (cycles >= DONE_CYCLE) begin
				$display("request %0d: done did not arrive within %0d cycles of start",
					num, DONE_CYCLE);
				$display("STATUS: FAIL");
				$fatal(1, "missing done");
			end
			check_value("busy while waiting", 32'(busy), 32'h1);
			check_value("result held", result, held);
			@(negedge clk);
			cycles++;
		end
		check_value("done cycle", cycles, DONE_CYCLE);
		check_value("busy on done", 32'(busy), 32'h1);
		check_value("result", result, expected);
		@(negedge clk);
		check_value("done after pulse", 32'(done), 32'h0);
		check_value("busy after done", 32'(busy), 32'h0);
		check_value("result after done", result, expected);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial begin
		logic [3:0]  kind;
		logic [2:0]  funct3;
		logic [6:0]  opcode;
		logic [7:0]  index;
		logic [1:0]  off;
		logic [31:0] expected;
		mem_req_t    r;
		lfsr  = 32'h9ebf_bf71;
		reset = 1'b1;
		start = 1'b0;
		req   = '0;
		for (int i = 0; i < RAM_WORDS * 4; i++)
			model_mem[i] = 8'h0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_value("busy after reset", 32'(busy), 32'h0);
		check_value("done after reset", 32'(done), 32'h0);
		check_value("result after reset", result, 32'h0);

		// cleared memory reads back as zero.
		for (int n = 0; n < RESET_REQ; n++) begin
			r.inst = {22'(take_bits(22)), F3_LW, OP_LOAD};
			r.data = take_bits(32);
			r.addr = {22'h0, 10'(take_bits(10))};
			run_request(n, r, 32'h0);
		end

		for (int n = RESET_REQ; n < NUM_REQ; n++) begin
			kind   = 4'(take_bits(4));
			funct3 = 3'(take_bits(3));
			if (take_bits(1) == 32'h1)
				index = 8'(take_bits(8));
			else
				index = 8'(take_bits(3));            // small window so loads hit stores.
			off    = 2'(take_bits(2));
			r.data = take_bits(32);
			r.addr = {22'h0, index, off};
			if (kind < 4'd7) begin
				opcode = OP_STORE;
				apply_store(r.addr, funct3, r.data);
				expected = 32'h0;
			end else if (kind < 4'd14) begin
				opcode   = OP_LOAD;
				expected = predict_load(r.addr, funct3);
			end else begin
				opcode = 7'(take_bits(7));
				if (opcode == OP_LOAD || opcode == OP_STORE)
					opcode = 7'b0110011;
				expected = 32'h0;                   // neither access nor write.
			end
			r.inst = {22'(take_bits(22)), funct3, opcode};
			run_request(n, r, expected);
		end

		$display("STATUS: PASS");
		$finish;
	end

	// bounds the whole run.
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$fatal(1, "timeout");
	end

endmodule

/* mem_stage.f */
common/mem_pkg.sv
src/data_ram.sv
src/load_store_align.sv
mem_ctrl/wait_counter.sv
mem_ctrl/mem_ctrl_fsm.sv
src/mem_stage_top.sv
bench/mem_stage_tb.sv

/* Makefile */
# Verilator build and run for mem_stage.

VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= mem_stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/1ps
PASS_TEXT ?= STATUS: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
